// File: hdl/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

  // --------------------------------------------------------------------------
  // instruction word types
  // --------------------------------------------------------------------------
  typedef logic [15:0] cinstr_t;
  typedef logic [31:0] instr_t;

  // expanded word plus the decoder's own reserved-encoding flag
  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } exp_result_t;

  // --------------------------------------------------------------------------
  // base major opcodes
  // --------------------------------------------------------------------------
  localparam logic [6:0] OpcodeLoad    = 7'b0000011;
  localparam logic [6:0] OpcodeStore   = 7'b0100011;
  localparam logic [6:0] OpcodeOpImm   = 7'b0010011;
  localparam logic [6:0] OpcodeOpImm32 = 7'b0011011;
  localparam logic [6:0] OpcodeOp      = 7'b0110011;
  localparam logic [6:0] OpcodeOp32    = 7'b0111011;
  localparam logic [6:0] OpcodeLui     = 7'b0110111;
  localparam logic [6:0] OpcodeBranch  = 7'b1100011;
  localparam logic [6:0] OpcodeJal     = 7'b1101111;
  localparam logic [6:0] OpcodeJalr    = 7'b1100111;

  // low two bits of a compressed word, 11 means a full-size instruction
  localparam logic [1:0] QuadC0 = 2'b00;
  localparam logic [1:0] QuadC1 = 2'b01;
  localparam logic [1:0] QuadC2 = 2'b10;

  // quadrant funct3 codes, bits 15:13
  localparam logic [2:0] C0Addi4spn    = 3'b000;
  localparam logic [2:0] C0Lw          = 3'b010;
  localparam logic [2:0] C0Ld          = 3'b011;
  localparam logic [2:0] C0Sw          = 3'b110;
  localparam logic [2:0] C0Sd          = 3'b111;

  localparam logic [2:0] C1Addi        = 3'b000;
  localparam logic [2:0] C1AddiwJal    = 3'b001;
  localparam logic [2:0] C1Li          = 3'b010;
  localparam logic [2:0] C1LuiAddi16sp = 3'b011;
  localparam logic [2:0] C1MiscAlu     = 3'b100;
  localparam logic [2:0] C1J           = 3'b101;
  localparam logic [2:0] C1Beqz        = 3'b110;
  localparam logic [2:0] C1Bnez        = 3'b111;

  localparam logic [2:0] C2Slli        = 3'b000;
  localparam logic [2:0] C2Lwsp        = 3'b010;
  localparam logic [2:0] C2Ldsp        = 3'b011;
  localparam logic [2:0] C2JalrMvAdd   = 3'b100;
  localparam logic [2:0] C2Swsp        = 3'b110;
  localparam logic [2:0] C2Sdsp        = 3'b111;

  // register numbers
  localparam logic [4:0] RegZero = 5'd0;
  localparam logic [4:0] RegRa   = 5'd1;
  localparam logic [4:0] RegSp   = 5'd2;

  // upper bits that map a 3-bit register field onto x8-x15
  localparam logic [1:0] RegPrimeHi = 2'b01;

  localparam instr_t InstrEbreak = 32'h0010_0073;

endpackage

`default_nettype wire

// File: hdl/rvc_c0_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_c0_decoder #(
  parameter int unsigned Xlen = 64
) (
  input  rvc_pkg::cinstr_t     cinstr_i,
  output rvc_pkg::exp_result_t result_o
);

  // rd'/rs2' sits in bits 4:2, rs1' in bits 9:7
  logic [4:0] rd_p;
  logic [4:0] rs1_p;

  assign rd_p  = {rvc_pkg::RegPrimeHi, cinstr_i[4:2]};
  assign rs1_p = {rvc_pkg::RegPrimeHi, cinstr_i[9:7]};

  always_comb begin
    result_o.instr   = {16'b0, cinstr_i};
    result_o.illegal = 1'b0;

    unique case (cinstr_i[15:13])
      rvc_pkg::C0Addi4spn: begin
        // addi rd', x2, nzuimm[9:2]
        result_o.instr = {2'b00, cinstr_i[10:7], cinstr_i[12:11], cinstr_i[5], cinstr_i[6],
                          2'b00, rvc_pkg::RegSp, 3'b000, rd_p, rvc_pkg::OpcodeOpImm};
        if (cinstr_i[12:5] == 8'b0) result_o.illegal = 1'b1;
      end

      rvc_pkg::C0Lw: begin
        // lw rd', uimm[6:2](rs1')
        result_o.instr = {5'b0, cinstr_i[5], cinstr_i[12:10], cinstr_i[6], 2'b00,
                          rs1_p, 3'b010, rd_p, rvc_pkg::OpcodeLoad};
      end

      rvc_pkg::C0Ld: begin
        // ld rd', uimm[7:3](rs1'), reserved on RV32
        result_o.instr = {4'b0, cinstr_i[6:5], cinstr_i[12:10], 3'b000,
                          rs1_p, 3'b011, rd_p, rvc_pkg::OpcodeLoad};
        if (Xlen != 64) result_o.illegal = 1'b1;
      end

      rvc_pkg::C0Sw: begin
        // sw rs2', uimm[6:2](rs1')
        result_o.instr = {5'b0, cinstr_i[5], cinstr_i[12], rd_p, rs1_p, 3'b010,
                          cinstr_i[11:10], cinstr_i[6], 2'b00, rvc_pkg::OpcodeStore};
      end

      rvc_pkg::C0Sd: begin
        // sd rs2', uimm[7:3](rs1')
        result_o.instr = {4'b0, cinstr_i[6:5], cinstr_i[12], rd_p, rs1_p, 3'b011,
                          cinstr_i[11:10], 3'b000, rvc_pkg::OpcodeStore};
        if (Xlen != 64) result_o.illegal = 1'b1;
      end

      // fld/fsd slots and the zcb slot 100 are not supported
      default: result_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rvc_c1_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_c1_decoder #(
  parameter int unsigned Xlen = 64
) (
  input  rvc_pkg::cinstr_t     cinstr_i,
  output rvc_pkg::exp_result_t result_o
);

  logic [4:0]  rd;
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  logic [11:0] imm_i;
  logic [19:0] jal_imm;

  assign rd    = cinstr_i[11:7];
  assign rd_p  = {rvc_pkg::RegPrimeHi, cinstr_i[9:7]};
  assign rs2_p = {rvc_pkg::RegPrimeHi, cinstr_i[4:2]};

  // sign-extended 6-bit immediate used by addi, addiw, li and andi
  assign imm_i = {{6{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};

  // jal immediate field in imm[20|10:1|11|19:12] order
  assign jal_imm = {cinstr_i[12], cinstr_i[8], cinstr_i[10:9], cinstr_i[6], cinstr_i[7],
                    cinstr_i[2], cinstr_i[11], cinstr_i[5:3], {9{cinstr_i[12]}}};

  always_comb begin
    result_o.instr   = {16'b0, cinstr_i};
    result_o.illegal = 1'b0;

    unique case (cinstr_i[15:13])
      rvc_pkg::C1Addi: begin
        // also covers c.nop
        result_o.instr = {imm_i, rd, 3'b000, rd, rvc_pkg::OpcodeOpImm};
      end

      rvc_pkg::C1AddiwJal: begin
        if (Xlen == 64) begin
          result_o.instr = {imm_i, rd, 3'b000, rd, rvc_pkg::OpcodeOpImm32};
        end else begin
          // RV32 uses this slot for c.jal
          result_o.instr = {jal_imm, rvc_pkg::RegRa, rvc_pkg::OpcodeJal};
        end
      end

      rvc_pkg::C1Li: begin
        result_o.instr = {imm_i, rvc_pkg::RegZero, 3'b000, rd, rvc_pkg::OpcodeOpImm};
      end

      rvc_pkg::C1LuiAddi16sp: begin
        if (rd == rvc_pkg::RegSp) begin
          // addi x2, x2, nzimm[9:4]
          result_o.instr = {{3{cinstr_i[12]}}, cinstr_i[4:3], cinstr_i[5], cinstr_i[2],
                            cinstr_i[6], 4'b0, rvc_pkg::RegSp, 3'b000, rvc_pkg::RegSp,
                            rvc_pkg::OpcodeOpImm};
        end else begin
          result_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd, rvc_pkg::OpcodeLui};
        end
        if ({cinstr_i[12], cinstr_i[6:2]} == 6'b0) result_o.illegal = 1'b1;
      end

      // ----------------------------------------------------------------------
      // misc alu group, all on the prime registers
      // ----------------------------------------------------------------------
      rvc_pkg::C1MiscAlu: begin
        unique case (cinstr_i[11:10])
          2'b00, 2'b01: begin
            // srli / srai, bit 10 selects the arithmetic shift
            result_o.instr = {1'b0, cinstr_i[10], 4'b0, cinstr_i[12], cinstr_i[6:2],
                              rd_p, 3'b101, rd_p, rvc_pkg::OpcodeOpImm};
          end

          2'b10: begin
            result_o.instr = {imm_i, rd_p, 3'b111, rd_p, rvc_pkg::OpcodeOpImm};
          end

          default: begin
            unique case ({cinstr_i[12], cinstr_i[6:5]})
              3'b000: result_o.instr = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p,
                                        rvc_pkg::OpcodeOp};
              3'b001: result_o.instr = {7'b0000000, rs2_p, rd_p, 3'b100, rd_p,
                                        rvc_pkg::OpcodeOp};
              3'b010: result_o.instr = {7'b0000000, rs2_p, rd_p, 3'b110, rd_p,
                                        rvc_pkg::OpcodeOp};
              3'b011: result_o.instr = {7'b0000000, rs2_p, rd_p, 3'b111, rd_p,
                                        rvc_pkg::OpcodeOp};
              // subw and addw
              3'b100: result_o.instr = {7'b0100000, rs2_p, rd_p, 3'b000, rd_p,
                                        rvc_pkg::OpcodeOp32};
              3'b101: result_o.instr = {7'b0000000, rs2_p, rd_p, 3'b000, rd_p,
                                        rvc_pkg::OpcodeOp32};
              // c.mul and the zcb unary ops are not supported
              default: result_o.illegal = 1'b1;
            endcase
          end
        endcase
      end

      rvc_pkg::C1J: begin
        result_o.instr = {jal_imm, rvc_pkg::RegZero, rvc_pkg::OpcodeJal};
      end

      default: begin
        // beqz / bnez, bit 13 picks bne
        result_o.instr = {{4{cinstr_i[12]}}, cinstr_i[6:5], cinstr_i[2], rvc_pkg::RegZero,
                          rd_p, 2'b00, cinstr_i[13], cinstr_i[11:10], cinstr_i[4:3],
                          cinstr_i[12], rvc_pkg::OpcodeBranch};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rvc_c2_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_c2_decoder #(
  parameter int unsigned Xlen = 64
) (
  input  rvc_pkg::cinstr_t     cinstr_i,
  output rvc_pkg::exp_result_t result_o
);

  // full 5-bit register fields in this quadrant
  logic [4:0] rd;
  logic [4:0] rs2;

  assign rd  = cinstr_i[11:7];
  assign rs2 = cinstr_i[6:2];

  always_comb begin
    result_o.instr   = {16'b0, cinstr_i};
    result_o.illegal = 1'b0;

    unique case (cinstr_i[15:13])
      rvc_pkg::C2Slli: begin
        result_o.instr = {6'b0, cinstr_i[12], cinstr_i[6:2], rd, 3'b001, rd,
                          rvc_pkg::OpcodeOpImm};
      end

      rvc_pkg::C2Lwsp: begin
        // lw rd, uimm[7:2](x2)
        result_o.instr = {4'b0, cinstr_i[3:2], cinstr_i[12], cinstr_i[6:4], 2'b00,
                          rvc_pkg::RegSp, 3'b010, rd, rvc_pkg::OpcodeLoad};
        if (rd == rvc_pkg::RegZero) result_o.illegal = 1'b1;
      end

      rvc_pkg::C2Ldsp: begin
        // ld rd, uimm[8:3](x2)
        result_o.instr = {3'b0, cinstr_i[4:2], cinstr_i[12], cinstr_i[6:5], 3'b000,
                          rvc_pkg::RegSp, 3'b011, rd, rvc_pkg::OpcodeLoad};
        if (rd == rvc_pkg::RegZero || Xlen != 64) result_o.illegal = 1'b1;
      end

      rvc_pkg::C2JalrMvAdd: begin
        if (!cinstr_i[12]) begin
          if (rs2 == rvc_pkg::RegZero) begin
            // jr needs a nonzero rs1
            result_o.instr = {12'b0, rd, 3'b000, rvc_pkg::RegZero, rvc_pkg::OpcodeJalr};
            if (rd == rvc_pkg::RegZero) result_o.illegal = 1'b1;
          end else begin
            result_o.instr = {7'b0, rs2, rvc_pkg::RegZero, 3'b000, rd, rvc_pkg::OpcodeOp};
          end
        end else if (rs2 == rvc_pkg::RegZero) begin
          if (rd == rvc_pkg::RegZero) begin
            result_o.instr = rvc_pkg::InstrEbreak;
          end else begin
            result_o.instr = {12'b0, rd, 3'b000, rvc_pkg::RegRa, rvc_pkg::OpcodeJalr};
          end
        end else begin
          result_o.instr = {7'b0, rs2, rd, 3'b000, rd, rvc_pkg::OpcodeOp};
        end
      end

      rvc_pkg::C2Swsp: begin
        // sw rs2, uimm[7:2](x2)
        result_o.instr = {4'b0, cinstr_i[8:7], cinstr_i[12], rs2, rvc_pkg::RegSp, 3'b010,
                          cinstr_i[11:9], 2'b00, rvc_pkg::OpcodeStore};
      end

      rvc_pkg::C2Sdsp: begin
        result_o.instr = {3'b0, cinstr_i[9:7], cinstr_i[12], rs2, rvc_pkg::RegSp, 3'b011,
                          cinstr_i[11:10], 3'b000, rvc_pkg::OpcodeStore};
        if (Xlen != 64) result_o.illegal = 1'b1;
      end

      // fldsp and the zcmt slot 101 are not supported
      default: result_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/rvc_expand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expand_stage #(
  parameter int unsigned Xlen = 64
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             valid_i,
  input  rvc_pkg::instr_t  instr_i,
  output logic             valid_o,
  output rvc_pkg::instr_t  instr_o,
  output logic             illegal_instr_o,
  output logic             is_compressed_o
);

  rvc_pkg::exp_result_t c0_res;
  rvc_pkg::exp_result_t c1_res;
  rvc_pkg::exp_result_t c2_res;
  rvc_pkg::exp_result_t sel_res;
  rvc_pkg::instr_t      exp_instr;
  logic                 exp_compressed;

  // --------------------------------------------------------------------------
  // quadrant decoders, all see the same low half-word
  // --------------------------------------------------------------------------
  rvc_c0_decoder #(.Xlen(Xlen)) c0_dec_i (
    .cinstr_i (instr_i[15:0]),
    .result_o (c0_res)
  );

  rvc_c1_decoder #(.Xlen(Xlen)) c1_dec_i (
    .cinstr_i (instr_i[15:0]),
    .result_o (c1_res)
  );

  rvc_c2_decoder #(.Xlen(Xlen)) c2_dec_i (
    .cinstr_i (instr_i[15:0]),
    .result_o (c2_res)
  );

  always_comb begin
    sel_res.instr   = instr_i;
    sel_res.illegal = 1'b0;
    exp_compressed  = 1'b1;

    unique case (instr_i[1:0])
      rvc_pkg::QuadC0: sel_res = c0_res;
      rvc_pkg::QuadC1: sel_res = c1_res;
      rvc_pkg::QuadC2: sel_res = c2_res;
      // full-size word goes through untouched
      default:         exp_compressed = 1'b0;
    endcase
  end

  // an illegal encoding hands the original word on
  assign exp_instr = sel_res.illegal ? instr_i : sel_res.instr;

  // --------------------------------------------------------------------------
  // output register, data held while no new word arrives
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      illegal_instr_o <= 1'b0;
      is_compressed_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        instr_o         <= exp_instr;
        illegal_instr_o <= sel_res.illegal;
        is_compressed_o <= exp_compressed;
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/rvc_expand_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rvc_expand_assert (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        valid_i,
  input logic [31:0] instr_i,
  input logic        valid_o,
  input logic [31:0] instr_o,
  input logic        illegal_instr_o,
  input logic        is_compressed_o
);

  // strobe is one register stage behind the input
  assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o == $past(valid_i))
    else $error("valid_o does not follow valid_i by one cycle");

  // full-size words come out unchanged
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (valid_o && !is_compressed_o) |-> instr_o == $past(instr_i))
    else $error("full-size word was modified");

  // illegal encodings hand the original word on
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (valid_o && illegal_instr_o) |-> instr_o == $past(instr_i))
    else $error("illegal word was not passed through");

endmodule

bind rvc_expand_stage rvc_expand_assert assert_i (
  .clk_i           (clk_i),
  .arst_n_i        (arst_n_i),
  .valid_i         (valid_i),
  .instr_i         (instr_i),
  .valid_o         (valid_o),
  .instr_o         (instr_o),
  .illegal_instr_o (illegal_instr_o),
  .is_compressed_o (is_compressed_o)
);

`default_nettype wire

// File: tests/tb_rvc_expand.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvc_expand;

  localparam int unsigned NumPass   = 200;
  localparam int unsigned NumForms  = 20;
  localparam int unsigned PerForm   = 20;
  localparam int unsigned NumFixed  = 8;
  localparam int unsigned NumCycles = 3 + NumPass + NumPass / 16 + NumForms * PerForm
                                      + NumFixed + 2;
  localparam int unsigned TimeoutNs = 2 * NumCycles * 4 + 200;

  // compressed forms as fixed funct3/quadrant bits plus a mask of random fields
  localparam logic [15:0] FormBits [NumForms] = '{
    16'h4000, 16'h6000, 16'hc000, 16'he000, 16'h0000, 16'h4002, 16'hc002, 16'h0001,
    16'h2001, 16'h4001, 16'h6001, 16'h8801, 16'h8c01, 16'ha001, 16'hc001, 16'he001,
    16'h0002, 16'h8002, 16'h8002, 16'h9002};
  localparam logic [15:0] FormMask [NumForms] = '{
    16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h1ffc,
    16'h1ffc, 16'h1ffc, 16'h1ffc, 16'h13fc, 16'h03fc, 16'h1ffc, 16'h1ffc, 16'h1ffc,
    16'h1ffc, 16'h1ffc, 16'h0f80, 16'h0f80};

  // addi4spn 0, lui 0, lwsp x0, jr x0, zcb slot, zcmt slot, c.mul, ebreak
  localparam logic [15:0] FixedWords [NumFixed] = '{
    16'h0000, 16'h6281, 16'h4012, 16'h8002, 16'h8444, 16'ha002, 16'h9cc9, 16'h9002};

  logic        clk_i;
  logic        arst_n_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic        valid_o;
  logic [31:0] instr_o;
  logic        illegal_instr_o;
  logic        is_compressed_o;

  // each entry is {illegal, compressed, instr}
  logic [33:0] exp_q[$];
  int          seed;

  rvc_expand_stage #(.Xlen(64)) dut_i (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .illegal_instr_o (illegal_instr_o),
    .is_compressed_o (is_compressed_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // base instruction formats
  // --------------------------------------------------------------------------
  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [6:0] op);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  // expected {illegal, compressed, instr} for one fetch word
  function automatic logic [33:0] ref_expand(input logic [31:0] w);
    logic [15:0] c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  p97;
    logic [4:0]  p42;
    logic [11:0] imm6;
    logic [11:0] u;
    logic [31:0] ins;
    logic        ill;
    c    = w[15:0];
    rd   = c[11:7];
    rs2  = c[6:2];
    p97  = {2'b01, c[9:7]};
    p42  = {2'b01, c[4:2]};
    imm6 = {{7{c[12]}}, c[6:2]};
    ill  = 1'b0;
    ins  = 32'h0;
    if (c[1:0] == 2'b11) return {2'b00, w};
    casez ({c[15:13], c[1:0]})
      5'b000_00: begin
        u   = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b0};
        ins = i_type(u, 5'd2, 3'd0, p42, 7'h13);
        ill = (u == 12'h0);
      end
      5'b010_00: ins = i_type({5'b0, c[5], c[12:10], c[6], 2'b0}, p97, 3'd2, p42, 7'h03);
      5'b011_00: ins = i_type({4'b0, c[6:5], c[12:10], 3'b0}, p97, 3'd3, p42, 7'h03);
      5'b110_00: ins = s_type({5'b0, c[5], c[12:10], c[6], 2'b0}, p42, p97, 3'd2, 7'h23);
      5'b111_00: ins = s_type({4'b0, c[6:5], c[12:10], 3'b0}, p42, p97, 3'd3, 7'h23);
      5'b000_01: ins = i_type(imm6, rd, 3'd0, rd, 7'h13);
      5'b001_01: ins = i_type(imm6, rd, 3'd0, rd, 7'h1b);
      5'b010_01: ins = i_type(imm6, 5'd0, 3'd0, rd, 7'h13);
      5'b011_01: begin
        if (rd == 5'd2) begin
          u   = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0};
          ins = i_type(u, 5'd2, 3'd0, 5'd2, 7'h13);
        end else begin
          ins = {{15{c[12]}}, c[6:2], rd, 7'h37};
        end
        ill = ({c[12], c[6:2]} == 6'h0);
      end
      5'b100_01: begin
        case (c[11:10])
          2'b00, 2'b01: ins = i_type({1'b0, c[10], 4'b0, c[12], c[6:2]}, p97, 3'd5, p97,
                                     7'h13);
          2'b10:        ins = i_type(imm6, p97, 3'd7, p97, 7'h13);
          default: begin
            case ({c[12], c[6:5]})
              3'b000:  ins = r_type(7'h20, p42, p97, 3'd0, p97);
              3'b001:  ins = r_type(7'h00, p42, p97, 3'd4, p97);
              3'b010:  ins = r_type(7'h00, p42, p97, 3'd6, p97);
              3'b011:  ins = r_type(7'h00, p42, p97, 3'd7, p97);
              3'b100:  ins = r_type(7'h20, p42, p97, 3'd0, p97) ^ 32'h08;
              3'b101:  ins = r_type(7'h00, p42, p97, 3'd0, p97) ^ 32'h08;
              default: ill = 1'b1;
            endcase
          end
        endcase
      end
      5'b101_01: ins = j_type({{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                               c[5:3], 1'b0}, 5'd0, 7'h6f);
      5'b11?_01: ins = b_type({{4{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0},
                              5'd0, p97, {2'b00, c[13]}, 7'h63);
      5'b000_10: ins = i_type({6'b0, c[12], c[6:2]}, rd, 3'd1, rd, 7'h13);
      5'b010_10: begin
        ins = i_type({4'b0, c[3:2], c[12], c[6:4], 2'b0}, 5'd2, 3'd2, rd, 7'h03);
        ill = (rd == 5'd0);
      end
      5'b100_10: begin
        if (!c[12] && rs2 == 5'd0) begin
          ins = i_type(12'h0, rd, 3'd0, 5'd0, 7'h67);
          ill = (rd == 5'd0);
        end else if (!c[12]) begin
          ins = r_type(7'h00, rs2, 5'd0, 3'd0, rd);
        end else if (rs2 != 5'd0) begin
          ins = r_type(7'h00, rs2, rd, 3'd0, rd);
        end else if (rd == 5'd0) begin
          ins = 32'h0010_0073;
        end else begin
          ins = i_type(12'h0, rd, 3'd0, 5'd1, 7'h67);
        end
      end
      5'b110_10: ins = s_type({4'b0, c[8:7], c[12:9], 2'b0}, rs2, 5'd2, 3'd2, 7'h23);
      default:   ill = 1'b1;
    endcase
    if (ill) ins = w;
    return {ill, 1'b1, ins};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Fail %s expected %h got %h", name, exp_val, act_val);
    $display("Checks failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic send(input logic [31:0] w);
    @(posedge clk_i);
    #1;
    valid_i = 1'b1;
    instr_i = w;
    exp_q.push_back(ref_expand(w));
  endtask

  task automatic idle();
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // compare every output word against the queued expectation
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    logic [33:0] exp_v;
    if (valid_o) begin
      assert (exp_q.size() != 0) else begin
        $display("valid_o pulsed with no expected word in the queue");
        $display("Checks failed");
        $fatal(1, "unexpected output word");
      end
      exp_v = exp_q.pop_front();
      assert (instr_o == exp_v[31:0])
        else report_mismatch("instr_o", exp_v[31:0], instr_o);
      assert (is_compressed_o == exp_v[32])
        else report_mismatch("is_compressed_o", 32'(exp_v[32]), 32'(is_compressed_o));
      assert (illegal_instr_o == exp_v[33])
        else report_mismatch("illegal_instr_o", 32'(exp_v[33]), 32'(illegal_instr_o));
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Run timed out before all words came out of the DUT");
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] r;
    int unsigned i;
    int unsigned f;
    seed     = 32'h2da8_bfc7;
    valid_i  = 1'b0;
    instr_i  = 32'h0;
    arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    assert (valid_o == 1'b0) else report_mismatch("valid_o", 32'h0, 32'(valid_o));

    // full-size words, streamed with a gap now and then
    for (i = 0; i < NumPass; i++) begin
      r = $random(seed);
      send({r[31:2], 2'b11});
      if (i % 16 == 15) idle();
    end

    // random fields in every compressed form, upper half random too
    for (f = 0; f < NumForms; f++) begin
      for (i = 0; i < PerForm; i++) begin
        r = $random(seed);
        send({r[31:16], (r[15:0] & FormMask[f]) | FormBits[f]});
      end
    end

    for (i = 0; i < NumFixed; i++) begin
      r = $random(seed);
      send({r[31:16], FixedWords[i]});
    end

    idle();
    idle();
    if (exp_q.size() == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("%0d expected words never came out", exp_q.size());
      $display("Checks failed");
      $fatal(1, "output words missing");
    end
  end

endmodule

`default_nettype wire

// File: build.f
hdl/rvc_pkg.sv
hdl/rvc_c0_decoder.sv
hdl/rvc_c1_decoder.sv
hdl/rvc_c2_decoder.sv
hdl/rvc_expand_stage.sv
tests/rvc_expand_assert.sv
tests/tb_rvc_expand.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_rvc_expand -f build.f \
  -o tb_rvc_expand > build.log 2>&1 &&
  ./obj_dir/tb_rvc_expand > sim.log 2>&1 ||
  { echo "build or simulation error"; cat build.log sim.log 2>/dev/null; }
grep -qx "All checks passed" sim.log && { echo "PASS"; exit 0; } ||
  { echo "FAIL"; exit 1; }
